// ==== rtl/cpu_defines.svh ====
// datapath width and count macros
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register file width
`define DATA_W 16

// index width for the eight registers
`define REG_ADDR_W 3

// register file depth
`define NUM_REGS 8

// opcode field width, top of the instruction
`define OPCODE_W 4

// immediate field width, low byte of the instruction
`define IMM_W 8

`endif

// ==== rtl/cpu_pkg.sv ====
// shared opcode and write-select types
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

   // opcode field in bits 15..12
   // values 9..15 are not decoded and act as nop
   typedef enum logic [`OPCODE_W-1:0] {
      op_nop  = 4'd0,
      op_add  = 4'd1,
      op_sub  = 4'd2,
      op_and  = 4'd3,
      op_xor  = 4'd4,
      // rd = (rs == rt)
      op_seq  = 4'd5,
      // rd = signed(rs) < signed(rt)
      op_slt  = 4'd6,
      // rd = sign-extended imm8
      op_lbi  = 4'd7,
      // rd = (rd << 8) | imm8
      op_slbi = 4'd8
   } opcode_t;

   // write-back source, same numbering as the full core's mux
   // 1 was the load path, 2 the pc increment, 6 and 7 spare
   typedef enum logic [2:0] {
      sel_alu  = 3'd0,
      sel_set  = 3'd3,
      sel_lbi  = 3'd4,
      sel_slbi = 3'd5
   } wr_sel_t;

endpackage

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// instruction decode and register file
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module decode_stage import cpu_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   instr_valid,
   input  logic [`DATA_W-1:0]     instr,
   // write port from MEM/WB
   input  logic                   wb_wr_en,
   input  logic [`REG_ADDR_W-1:0] wb_rd,
   input  logic [`DATA_W-1:0]     wb_data,
   // ID/EX register
   output logic                   ex_valid,
   output opcode_t                ex_op,
   output logic [`REG_ADDR_W-1:0] ex_rd,
   output logic [`REG_ADDR_W-1:0] ex_rs,
   output logic [`REG_ADDR_W-1:0] ex_rt,
   output logic                   ex_has_rt,
   output logic [`DATA_W-1:0]     ex_rs_val,
   output logic [`DATA_W-1:0]     ex_rt_val,
   output logic [`IMM_W-1:0]      ex_imm,
   output logic                   ex_wr_en,
   output wr_sel_t                ex_wr_sel
);

   logic [`DATA_W-1:0]     regs [`NUM_REGS];
   opcode_t                raw_op;
   opcode_t                dec_op;
   logic [`REG_ADDR_W-1:0] rd_field;
   logic [`REG_ADDR_W-1:0] rs_addr;
   logic [`REG_ADDR_W-1:0] rt_addr;
   logic                   has_rt;
   logic                   wr_en;
   wr_sel_t                wr_sel;
   logic [`DATA_W-1:0]     rs_val;
   logic [`DATA_W-1:0]     rt_val;

   // fixed field positions
   assign raw_op   = opcode_t'(instr[15:12]);
   assign rd_field = instr[11:9];
   // slbi shifts its own destination, so rd is the source
   assign rs_addr  = (raw_op == op_slbi) ? rd_field : instr[8:6];
   assign rt_addr  = instr[5:3];

   // opcode to control
   always_comb begin
      dec_op = op_nop;
      has_rt = 1'b0;
      wr_en  = 1'b0;
      wr_sel = sel_alu;
      case (raw_op)
         op_add, op_sub, op_and, op_xor: begin
            dec_op = raw_op;
            has_rt = 1'b1;
            wr_en  = 1'b1;
         end
         op_seq, op_slt: begin
            dec_op = raw_op;
            has_rt = 1'b1;
            wr_en  = 1'b1;
            wr_sel = sel_set;
         end
         op_lbi: begin
            dec_op = raw_op;
            wr_en  = 1'b1;
            wr_sel = sel_lbi;
         end
         op_slbi: begin
            dec_op = raw_op;
            wr_en  = 1'b1;
            wr_sel = sel_slbi;
         end
         // nop and unknown codes stay a bubble
         default: dec_op = op_nop;
      endcase
   end

   // read ports, write-before-read bypass for distance three
   always_comb begin
      rs_val = regs[rs_addr];
      rt_val = regs[rt_addr];
      if (wb_wr_en && (wb_rd == rs_addr))
         rs_val = wb_data;
      if (wb_wr_en && (wb_rd == rt_addr))
         rt_val = wb_data;
   end

   // register file, cleared so early reads return zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++)
            regs[i] <= '0;
      end else if (wb_wr_en) begin
         regs[wb_rd] <= wb_data;
      end
   end

   // ID/EX control, no valid input means bubble
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_valid  <= 1'b0;
         ex_wr_en  <= 1'b0;
         ex_has_rt <= 1'b0;
         ex_op     <= op_nop;
         ex_wr_sel <= sel_alu;
      end else begin
         ex_valid  <= instr_valid;
         ex_wr_en  <= instr_valid & wr_en;
         ex_has_rt <= instr_valid & has_rt;
         ex_op     <= instr_valid ? dec_op : op_nop;
         ex_wr_sel <= wr_sel;
      end
   end

   // ID/EX payload, only loaded on a real instruction
   always_ff @(posedge clk) begin
      if (instr_valid) begin
         ex_rd     <= rd_field;
         ex_rs     <= rs_addr;
         ex_rt     <= rt_addr;
         ex_rs_val <= rs_val;
         ex_rt_val <= rt_val;
         ex_imm    <= instr[7:0];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/forward_unit.sv ====
// operand forwarding
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module forward_unit (
   // ID/EX sources
   input  logic [`REG_ADDR_W-1:0] ex_rs,
   input  logic [`REG_ADDR_W-1:0] ex_rt,
   input  logic                   ex_has_rt,
   input  logic [`DATA_W-1:0]     ex_rs_val,
   input  logic [`DATA_W-1:0]     ex_rt_val,
   // EX/MEM destination and its selected value
   input  logic                   mem_wr_en,
   input  logic [`REG_ADDR_W-1:0] mem_rd,
   input  logic [`DATA_W-1:0]     mem_wr_data,
   // MEM/WB destination
   input  logic                   wb_wr_en,
   input  logic [`REG_ADDR_W-1:0] wb_rd,
   input  logic [`DATA_W-1:0]     wb_data,
   // operands for execute
   output logic [`DATA_W-1:0]     op_rs,
   output logic [`DATA_W-1:0]     op_rt
);

   logic mem_hit_rs;
   logic mem_hit_rt;
   logic wb_hit_rs;
   logic wb_hit_rt;

   // distance one hits on the EX/MEM write
   assign mem_hit_rs = mem_wr_en & (mem_rd == ex_rs);
   assign mem_hit_rt = mem_wr_en & ex_has_rt & (mem_rd == ex_rt);

   // distance two hits on the MEM/WB write
   assign wb_hit_rs = wb_wr_en & (wb_rd == ex_rs);
   assign wb_hit_rt = wb_wr_en & ex_has_rt & (wb_rd == ex_rt);

   // EX/MEM first, then MEM/WB, then the value read in decode
   always_comb begin
      op_rs = ex_rs_val;
      op_rt = ex_rt_val;
      if (mem_hit_rs)
         op_rs = mem_wr_data;
      else if (wb_hit_rs)
         op_rs = wb_data;
      if (mem_hit_rt)
         op_rt = mem_wr_data;
      else if (wb_hit_rt)
         op_rt = wb_data;
   end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// execute stage and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module execute_stage import cpu_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   // ID/EX
   input  logic                   ex_valid,
   input  opcode_t                ex_op,
   input  logic [`REG_ADDR_W-1:0] ex_rd,
   input  logic [`IMM_W-1:0]      ex_imm,
   input  logic                   ex_wr_en,
   input  wr_sel_t                ex_wr_sel,
   // forwarded operands
   input  logic [`DATA_W-1:0]     op_rs,
   input  logic [`DATA_W-1:0]     op_rt,
   // EX/MEM register
   output logic                   mem_wr_en,
   output logic [`REG_ADDR_W-1:0] mem_rd,
   output wr_sel_t                mem_wr_sel,
   output logic [`DATA_W-1:0]     mem_alu_result,
   output logic [`DATA_W-1:0]     mem_set_result,
   output logic [`DATA_W-1:0]     mem_lbi_result,
   output logic [`DATA_W-1:0]     mem_slbi_result
);

   logic [`DATA_W-1:0] alu_result;
   logic               set_bit;
   logic [`DATA_W-1:0] lbi_result;
   logic [`DATA_W-1:0] slbi_result;

   // alu, sub is rs minus rt
   always_comb begin
      case (ex_op)
         op_add:  alu_result = op_rs + op_rt;
         op_sub:  alu_result = op_rs - op_rt;
         op_and:  alu_result = op_rs & op_rt;
         op_xor:  alu_result = op_rs ^ op_rt;
         default: alu_result = '0;
      endcase
   end

   // set ops give a single bit
   always_comb begin
      case (ex_op)
         op_seq:  set_bit = (op_rs == op_rt);
         op_slt:  set_bit = ($signed(op_rs) < $signed(op_rt));
         default: set_bit = 1'b0;
      endcase
   end

   // immediates
   assign lbi_result  = {{(`DATA_W-`IMM_W){ex_imm[`IMM_W-1]}}, ex_imm};
   // old rd arrives on op_rs, low byte moves up
   assign slbi_result = {op_rs[`DATA_W-`IMM_W-1:0], ex_imm};

   // EX/MEM control
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_wr_en  <= 1'b0;
         mem_rd     <= '0;
         mem_wr_sel <= sel_alu;
      end else begin
         mem_wr_en  <= ex_valid & ex_wr_en;
         mem_rd     <= ex_rd;
         mem_wr_sel <= ex_wr_sel;
      end
   end

   // EX/MEM results, held through bubbles
   always_ff @(posedge clk) begin
      if (ex_valid) begin
         mem_alu_result  <= alu_result;
         mem_set_result  <= {{(`DATA_W-1){1'b0}}, set_bit};
         mem_lbi_result  <= lbi_result;
         mem_slbi_result <= slbi_result;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/result_stage.sv ====
// write-back select and MEM/WB register
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module result_stage import cpu_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   // EX/MEM
   input  logic                   mem_wr_en,
   input  logic [`REG_ADDR_W-1:0] mem_rd,
   input  wr_sel_t                mem_wr_sel,
   input  logic [`DATA_W-1:0]     mem_alu_result,
   input  logic [`DATA_W-1:0]     mem_set_result,
   input  logic [`DATA_W-1:0]     mem_lbi_result,
   input  logic [`DATA_W-1:0]     mem_slbi_result,
   // selected value, also the distance-one forward
   output logic [`DATA_W-1:0]     mem_wr_data,
   // MEM/WB register
   output logic                   wb_wr_en,
   output logic [`REG_ADDR_W-1:0] wb_rd,
   output logic [`DATA_W-1:0]     wb_data
);

   // eight-way select, unused codes read as zero
   always_comb begin
      case (mem_wr_sel)
         sel_alu:  mem_wr_data = mem_alu_result;
         sel_set:  mem_wr_data = mem_set_result;
         sel_lbi:  mem_wr_data = mem_lbi_result;
         sel_slbi: mem_wr_data = mem_slbi_result;
         default:  mem_wr_data = '0;
      endcase
   end

   // MEM/WB control
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_wr_en <= 1'b0;
         wb_rd    <= '0;
      end else begin
         wb_wr_en <= mem_wr_en;
         wb_rd    <= mem_rd;
      end
   end

   // write value only moves with a real write
   always_ff @(posedge clk) begin
      if (mem_wr_en)
         wb_data <= mem_wr_data;
   end

endmodule

`default_nettype wire

// ==== rtl/pipe_top.sv ====
// three-stage register pipeline top
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module pipe_top import cpu_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   instr_valid,
   input  logic [`DATA_W-1:0]     instr,
   output logic                   wb_valid,
   output logic [`REG_ADDR_W-1:0] wb_rd,
   output logic [`DATA_W-1:0]     wb_data
);

   // ID/EX
   logic                   ex_valid;
   opcode_t                ex_op;
   logic [`REG_ADDR_W-1:0] ex_rd;
   logic [`REG_ADDR_W-1:0] ex_rs;
   logic [`REG_ADDR_W-1:0] ex_rt;
   logic                   ex_has_rt;
   logic [`DATA_W-1:0]     ex_rs_val;
   logic [`DATA_W-1:0]     ex_rt_val;
   logic [`IMM_W-1:0]      ex_imm;
   logic                   ex_wr_en;
   wr_sel_t                ex_wr_sel;
   // forwarded operands
   logic [`DATA_W-1:0]     op_rs;
   logic [`DATA_W-1:0]     op_rt;
   // EX/MEM
   logic                   mem_wr_en;
   logic [`REG_ADDR_W-1:0] mem_rd;
   wr_sel_t                mem_wr_sel;
   logic [`DATA_W-1:0]     mem_alu_result;
   logic [`DATA_W-1:0]     mem_set_result;
   logic [`DATA_W-1:0]     mem_lbi_result;
   logic [`DATA_W-1:0]     mem_slbi_result;
   logic [`DATA_W-1:0]     mem_wr_data;
   // MEM/WB write enable, rd and data drive the ports directly
   logic                   wb_wr_en;

   // every MEM/WB write is a retiring result
   assign wb_valid = wb_wr_en;

   decode_stage decode_i (
      .clk, .rst_n, .instr_valid, .instr,
      .wb_wr_en, .wb_rd, .wb_data,
      .ex_valid, .ex_op, .ex_rd, .ex_rs, .ex_rt, .ex_has_rt,
      .ex_rs_val, .ex_rt_val, .ex_imm, .ex_wr_en, .ex_wr_sel
   );

   forward_unit forward_i (
      .ex_rs, .ex_rt, .ex_has_rt, .ex_rs_val, .ex_rt_val,
      .mem_wr_en, .mem_rd, .mem_wr_data,
      .wb_wr_en, .wb_rd, .wb_data,
      .op_rs, .op_rt
   );

   execute_stage execute_i (
      .clk, .rst_n,
      .ex_valid, .ex_op, .ex_rd, .ex_imm, .ex_wr_en, .ex_wr_sel,
      .op_rs, .op_rt,
      .mem_wr_en, .mem_rd, .mem_wr_sel,
      .mem_alu_result, .mem_set_result, .mem_lbi_result, .mem_slbi_result
   );

   // selected EX/MEM value loops back into forwarding
   result_stage result_i (
      .clk, .rst_n,
      .mem_wr_en, .mem_rd, .mem_wr_sel,
      .mem_alu_result, .mem_set_result, .mem_lbi_result, .mem_slbi_result,
      .mem_wr_data, .wb_wr_en, .wb_rd, .wb_data
   );

endmodule

`default_nettype wire

// ==== testbench/pipe_checker.sv ====
// pipeline assertion checker
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module pipe_checker (
   input logic               clk,
   input logic               rst_n,
   input logic               instr_valid,
   input logic               wb_valid,
   input logic [`DATA_W-1:0] wb_data
);

   // cycles since reset release, stops at three
   logic [1:0] run_cycles;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         run_cycles <= '0;
      else if (run_cycles != 2'd3)
         run_cycles <= run_cycles + 2'd1;
   end

   // nothing can retire while the pipe is still filling
   assert property (@(posedge clk) (!rst_n || run_cycles != 2'd3) |-> !wb_valid)
      else $error("write-back during reset or pipeline fill");

   // retired data is always known
   assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> !$isunknown(wb_data))
      else $error("unknown write-back data");

   // fixed latency of three
   assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> $past(instr_valid, 3))
      else $error("write-back without an instruction three cycles earlier");

endmodule

bind pipe_top pipe_checker checker_i (
   .clk, .rst_n, .instr_valid, .wb_valid, .wb_data
);

`default_nettype wire

// ==== testbench/pipe_tb.sv ====
// pipeline testbench with reference model
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module pipe_tb ();

   localparam int MIX_COUNT = 2000;
   // reset, reset test, seeding, the four directed loops, set test, drain
   localparam int DIRECTED_SLOTS = 2 + 22 + 16 + 2*200 + 3*150 + 4*150 + 3*150 + 106 + 4;
   // a mix instruction takes at most two slots
   localparam int MAX_CYCLES = DIRECTED_SLOTS + 2 * MIX_COUNT + 20;

   logic                   clk;
   logic                   rst_n;
   logic                   instr_valid;
   logic [`DATA_W-1:0]     instr;
   logic                   wb_valid;
   logic [`REG_ADDR_W-1:0] wb_rd;
   logic [`DATA_W-1:0]     wb_data;

   // architectural state and outstanding write-backs
   logic [`DATA_W-1:0]     model_regs [`NUM_REGS];
   logic [`REG_ADDR_W-1:0] exp_rd [$];
   logic [`DATA_W-1:0]     exp_data [$];
   int                     exp_slot [$];
   int                     slot = 0;
   int                     cycle_count = 0;
   string                  test_name;

   pipe_top dut_i (
      .clk, .rst_n, .instr_valid, .instr, .wb_valid, .wb_rd, .wb_data
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // hang guard
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout after %0d cycles in test %s", MAX_CYCLES, test_name);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic abort_run(input string why);
      $display("%s in test %s", why, test_name);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_equal(input string what, input logic [`DATA_W-1:0] expected,
                              input logic [`DATA_W-1:0] actual);
      if (actual !== expected) begin
         $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // reference execution in program order, straight from the ISA rules
   task automatic run_model(input logic [`DATA_W-1:0] word);
      logic [`REG_ADDR_W-1:0] rd;
      logic [`DATA_W-1:0]     a;
      logic [`DATA_W-1:0]     b;
      logic [`DATA_W-1:0]     res;
      logic [7:0]             imm;
      logic                   writes;
      rd     = word[11:9];
      a      = model_regs[word[8:6]];
      b      = model_regs[word[5:3]];
      imm    = word[7:0];
      writes = 1'b1;
      case (word[15:12])
         4'd1: res = a + b;
         4'd2: res = a - b;
         4'd3: res = a & b;
         4'd4: res = a ^ b;
         4'd5: res = (a == b) ? 16'd1 : 16'd0;
         4'd6: res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
         4'd7: res = {{8{imm[7]}}, imm};
         // old destination shifted up
         4'd8: res = {model_regs[rd][7:0], imm};
         default: begin
            res    = '0;
            writes = 1'b0;
         end
      endcase
      if (writes) begin
         model_regs[rd] = res;
         exp_rd.push_back(rd);
         exp_data.push_back(res);
         exp_slot.push_back(slot);
      end
   endtask

   // outputs are settled one ns after the edge
   task automatic check_writeback();
      if (wb_valid === 1'b1) begin
         if (exp_rd.size() == 0) begin
            abort_run("write-back with no instruction outstanding");
         end else begin
            check_equal("rd", `DATA_W'(exp_rd[0]), `DATA_W'(wb_rd));
            check_equal("data", exp_data[0], wb_data);
            check_equal("latency", 16'd3, 16'(slot - exp_slot[0]));
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_slot.pop_front());
         end
      end else if (wb_valid !== 1'b0) begin
         abort_run("wb_valid is unknown");
      end
   endtask

   // one cycle, check first then drive
   task automatic issue_slot(input logic valid, input logic [`DATA_W-1:0] word);
      @(posedge clk);
      #1;
      slot++;
      check_writeback();
      instr_valid = valid;
      instr       = word;
      if (valid)
         run_model(word);
   endtask

   function automatic logic [`DATA_W-1:0] rtype_word(input logic [3:0] op, input int rd,
                                                     input int rs, input int rt);
      return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
   endfunction

   function automatic logic [`DATA_W-1:0] imm_word(input logic [3:0] op, input int rd,
                                                   input logic [7:0] imm);
      return {op, 3'(rd), 1'b0, imm};
   endfunction

   function automatic logic [3:0] random_op();
      return 4'($urandom_range(1, 6));
   endfunction

   function automatic int random_reg();
      return $urandom_range(0, 7);
   endfunction

   // nine in ten decode, the rest are undecoded codes
   function automatic logic [`DATA_W-1:0] random_word();
      logic [3:0] op;
      op = 4'($urandom_range(0, 9));
      if (op == 4'd9)
         op = 4'($urandom_range(9, 15));
      return {op, 12'($urandom)};
   endfunction

   task automatic issue_rrr(input logic [3:0] op, input int rd, input int rs, input int rt);
      issue_slot(1'b1, rtype_word(op, rd, rs, rt));
   endtask

   initial begin
      int a;
      int b;
      void'($urandom(13127));
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      test_name   = "reset";
      for (int i = 0; i < `NUM_REGS; i++)
         model_regs[i] = '0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;

      // idle, nop and undecoded slots retire nothing
      test_name = "reset and bubbles";
      repeat (4) issue_slot(1'b0, '0);
      for (int i = 0; i < 16; i++)
         issue_slot(1'b1, {(i < 8) ? 4'd0 : 4'($urandom_range(9, 15)), 12'($urandom)});
      // untouched registers read zero
      issue_rrr(4'd1, 1, 2, 3);
      issue_rrr(4'd5, 4, 5, 6);

      test_name = "register seeding";
      for (int r = 0; r < `NUM_REGS; r++) begin
         issue_slot(1'b1, imm_word(4'd7, r, 8'($urandom)));
         issue_slot(1'b1, imm_word(4'd8, r, 8'($urandom)));
      end

      // consumer right behind its producer
      test_name = "ex/mem forwarding";
      repeat (200) begin
         a = random_reg();
         issue_rrr(random_op(), a, random_reg(), random_reg());
         b = $urandom_range(0, 1);
         issue_rrr(random_op(), random_reg(), b ? a : random_reg(), b ? random_reg() : a);
      end

      // distance two, middle slot sometimes writes the same register
      test_name = "mem/wb forwarding";
      repeat (150) begin
         a = random_reg();
         issue_rrr(random_op(), a, random_reg(), random_reg());
         b = $urandom_range(0, 1) ? a : random_reg();
         issue_rrr(random_op(), b, random_reg(), random_reg());
         issue_rrr(random_op(), random_reg(), a, a);
      end

      // distance three, fillers are idle slots or nops
      test_name = "register file bypass";
      repeat (150) begin
         a = random_reg();
         issue_rrr(random_op(), a, random_reg(), random_reg());
         issue_slot(1'($urandom_range(0, 1)), '0);
         issue_slot(1'b1, '0);
         issue_rrr(random_op(), random_reg(), a, a);
      end

      // lbi then slbi builds a full constant, then gets used
      test_name = "immediates";
      repeat (150) begin
         a = random_reg();
         issue_slot(1'b1, imm_word(4'd7, a, 8'($urandom)));
         issue_slot(1'b1, imm_word(4'd8, a, 8'($urandom)));
         issue_rrr(4'd1, random_reg(), a, a);
      end

      // r1 8000, r2 7fff, r3 ffff, r4 zero
      test_name = "set operations";
      issue_slot(1'b1, imm_word(4'd7, 1, 8'h80));
      issue_slot(1'b1, imm_word(4'd8, 1, 8'h00));
      issue_slot(1'b1, imm_word(4'd7, 2, 8'h7f));
      issue_slot(1'b1, imm_word(4'd8, 2, 8'hff));
      issue_slot(1'b1, imm_word(4'd7, 3, 8'hff));
      issue_slot(1'b1, imm_word(4'd7, 4, 8'h00));
      repeat (100)
         issue_rrr(4'($urandom_range(5, 6)), $urandom_range(5, 7), $urandom_range(1, 4),
                   $urandom_range(1, 4));

      // garbage on instr during gaps must be ignored
      test_name = "random mix";
      repeat (MIX_COUNT) begin
         if ($urandom_range(0, 3) == 0)
            issue_slot(1'b0, 16'($urandom));
         issue_slot(1'b1, random_word());
      end

      test_name = "drain";
      repeat (4) issue_slot(1'b0, '0);
      if (exp_rd.size() != 0) begin
         $display("%0d expected write-backs never retired", exp_rd.size());
         $display("TEST FAILED");
         $fatal(1, "missing write-back");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/decode_stage.sv
rtl/forward_unit.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/pipe_top.sv
testbench/pipe_checker.sv
testbench/pipe_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pipe_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) rtl/cpu_defines.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)
